/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
+incdir+include
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
source/rv_decoder.sv
source/rv_execute.sv
source/rv_regfile.sv
source/rv_commit.sv
source/rv_core.sv
test/tb_clock_gen.sv
test/rv_core_properties.sv
test/tb_rv_core.sv

/* include/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data word width, rv32
`define RV_XLEN 32

// register index width
`define RV_REG_AW 5

// architectural register count, x0 included
`define RV_NUM_REGS 32

// fetch address right after reset
`define RV_RESET_PC 32'h8000_0000

`endif

/* source/rv_commit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_commit (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire rv_isa_pkg::word_t    next_pc,
  input  wire rv_isa_pkg::word_t    sum,
  input  wire rv_isa_pkg::word_t    link,
  input  wire rv_ctrl_pkg::wb_sel_e wb_sel,
  input  wire logic                 rf_wen,
  input  wire logic                 halt_req,
  output rv_isa_pkg::word_t         pc,
  output logic                      halt,
  output rv_isa_pkg::word_t         rd_wdata,
  output logic                      rd_wen
);

  // pc and halt state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      if (halt_req) begin
        // ebreak holds the pc on its own address
        halt <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

  // write-back value
  // link for jal / jalr, adder result otherwise
  assign rd_wdata = (wb_sel == rv_ctrl_pkg::LINK) ? link : sum;

  // no writes in reset or once halted
  assign rd_wen = rf_wen && !halt && rst_n;

endmodule

`default_nettype wire

/* source/rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_core (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire rv_isa_pkg::inst_u inst,
  output rv_isa_pkg::word_t      pc,
  output logic                   halt
);

  // decode outputs
  rv_ctrl_pkg::op_a_sel_e op_a_sel;
  rv_isa_pkg::word_t      imm;
  rv_ctrl_pkg::wb_sel_e   wb_sel;
  rv_ctrl_pkg::pc_sel_e   pc_sel;
  logic                   rf_wen;
  rv_isa_pkg::reg_addr_t  rs1_addr;
  rv_isa_pkg::reg_addr_t  rd_addr;
  logic                   halt_req;

  // register file read
  rv_isa_pkg::word_t      rs1_data;

  // execute results
  rv_isa_pkg::word_t      sum;
  rv_isa_pkg::word_t      link;
  rv_isa_pkg::word_t      next_pc;

  // gated write-back
  rv_isa_pkg::word_t      rd_wdata;
  logic                   rd_wen;

  rv_decoder u_decoder (
    .inst     (inst),
    .op_a_sel (op_a_sel),
    .imm      (imm),
    .wb_sel   (wb_sel),
    .pc_sel   (pc_sel),
    .rf_wen   (rf_wen),
    .rs1_addr (rs1_addr),
    .rd_addr  (rd_addr),
    .halt_req (halt_req)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rd_addr  (rd_addr),
    .rd_wdata (rd_wdata),
    .rd_wen   (rd_wen),
    .rs1_data (rs1_data)
  );

  rv_execute u_execute (
    .op_a_sel (op_a_sel),
    .imm      (imm),
    .rs1_data (rs1_data),
    .pc       (pc),
    .pc_sel   (pc_sel),
    .sum      (sum),
    .link     (link),
    .next_pc  (next_pc)
  );

  // owns pc and halt, closes the loop back to the regfile
  rv_commit u_commit (
    .clk      (clk),
    .rst_n    (rst_n),
    .next_pc  (next_pc),
    .sum      (sum),
    .link     (link),
    .wb_sel   (wb_sel),
    .rf_wen   (rf_wen),
    .halt_req (halt_req),
    .pc       (pc),
    .halt     (halt),
    .rd_wdata (rd_wdata),
    .rd_wen   (rd_wen)
  );

endmodule

`default_nettype wire

/* source/rv_ctrl_pkg.sv */
`default_nettype none

`include "rv_core_cfg.svh"

package rv_ctrl_pkg;

  // adder operand a source
  typedef enum logic [1:0] {
    REG  = 2'd0,
    PC   = 2'd1,
    ZERO = 2'd2
  } op_a_sel_e;

  // register write-back source
  // sum is the adder result, link is pc + 4
  typedef enum logic {
    SUM  = 1'b0,
    LINK = 1'b1
  } wb_sel_e;

  // next pc source
  typedef enum logic {
    SEQ    = 1'b0,
    TARGET = 1'b1
  } pc_sel_e;

  // jump targets drop bit 0 (jalr rule, harmless for jal)
  localparam logic [`RV_XLEN-1:0] TARGET_MASK = ~`RV_XLEN'(1);

endpackage

`default_nettype wire

/* source/rv_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_decoder (
  input  wire rv_isa_pkg::inst_u      inst,
  output rv_ctrl_pkg::op_a_sel_e      op_a_sel,
  output rv_isa_pkg::word_t           imm,
  output rv_ctrl_pkg::wb_sel_e        wb_sel,
  output rv_ctrl_pkg::pc_sel_e        pc_sel,
  output logic                        rf_wen,
  output rv_isa_pkg::reg_addr_t       rs1_addr,
  output rv_isa_pkg::reg_addr_t       rd_addr,
  output logic                        halt_req
);

  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t imm_u;
  rv_isa_pkg::word_t imm_j;

  // register fields sit at the same bits in both views
  assign rs1_addr = inst.i.rs1;
  assign rd_addr  = inst.i.rd;

  // i immediate, sign extended from bit 11
  assign imm_i = {{(`RV_XLEN-12){inst.i.imm[11]}}, inst.i.imm};

  // u immediate lands in the upper 20 bits
  assign imm_u = {inst.u.imm, 12'h000};

  // j immediate unscrambled from the u field
  // u.imm[19] = inst[31], u.imm[18:9] = inst[30:21]
  // u.imm[8] = inst[20], u.imm[7:0] = inst[19:12]
  assign imm_j = {
    {(`RV_XLEN-21){inst.u.imm[19]}},
    inst.u.imm[19],
    inst.u.imm[7:0],
    inst.u.imm[8],
    inst.u.imm[18:9],
    1'b0
  };

  always_comb begin
    // defaults describe a no-op, pc + 4 and no write
    op_a_sel = rv_ctrl_pkg::ZERO;
    imm      = '0;
    wb_sel   = rv_ctrl_pkg::SUM;
    pc_sel   = rv_ctrl_pkg::SEQ;
    rf_wen   = 1'b0;
    halt_req = 1'b0;

    case (inst.u.opcode)
      // funct3 ignored, everything here is addi
      rv_isa_pkg::OP_IMM: begin
        op_a_sel = rv_ctrl_pkg::REG;
        imm      = imm_i;
        rf_wen   = 1'b1;
      end
      // zero + imm, so the immediate alone
      rv_isa_pkg::LUI: begin
        op_a_sel = rv_ctrl_pkg::ZERO;
        imm      = imm_u;
        rf_wen   = 1'b1;
      end
      rv_isa_pkg::AUIPC: begin
        op_a_sel = rv_ctrl_pkg::PC;
        imm      = imm_u;
        rf_wen   = 1'b1;
      end
      // pc-relative jump, rd gets the link
      rv_isa_pkg::JAL: begin
        op_a_sel = rv_ctrl_pkg::PC;
        imm      = imm_j;
        wb_sel   = rv_ctrl_pkg::LINK;
        pc_sel   = rv_ctrl_pkg::TARGET;
        rf_wen   = 1'b1;
      end
      // register-relative jump, rd gets the link
      rv_isa_pkg::JALR: begin
        op_a_sel = rv_ctrl_pkg::REG;
        imm      = imm_i;
        wb_sel   = rv_ctrl_pkg::LINK;
        pc_sel   = rv_ctrl_pkg::TARGET;
        rf_wen   = 1'b1;
      end
      // only ebreak (imm 1) does anything, ecall falls through as a no-op
      rv_isa_pkg::SYSTEM: begin
        halt_req = (inst.i.imm == 12'd1);
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/rv_execute.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_execute (
  input  wire rv_ctrl_pkg::op_a_sel_e op_a_sel,
  input  wire rv_isa_pkg::word_t      imm,
  input  wire rv_isa_pkg::word_t      rs1_data,
  input  wire rv_isa_pkg::word_t      pc,
  input  wire rv_ctrl_pkg::pc_sel_e   pc_sel,
  output rv_isa_pkg::word_t           sum,
  output rv_isa_pkg::word_t           link,
  output rv_isa_pkg::word_t           next_pc
);

  rv_isa_pkg::word_t op_a;

  // operand a mux
  always_comb begin
    case (op_a_sel)
      rv_ctrl_pkg::REG: begin
        op_a = rs1_data;
      end
      rv_ctrl_pkg::PC: begin
        op_a = pc;
      end
      default: begin
        op_a = '0;
      end
    endcase
  end

  // single adder shared by every instruction
  assign sum = op_a + imm;

  // sequential pc, also the jump link value
  assign link = pc + `RV_XLEN'(4);

  // jumps take the adder result with bit 0 cleared
  assign next_pc = (pc_sel == rv_ctrl_pkg::TARGET) ?
                   (sum & rv_ctrl_pkg::TARGET_MASK) : link;

endmodule

`default_nettype wire

/* source/rv_isa_pkg.sv */
`default_nettype none

`include "rv_core_cfg.svh"

package rv_isa_pkg;

  // one data word
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // major opcodes kept by this core
  // anything else decodes as a no-op
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // i-type layout, op-imm / jalr / system
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // u-type layout, lui / auipc
  // jal reuses the same 20 upper bits, scrambled
  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    opcode_e     opcode;
  } u_fmt_t;

  // same instruction word, two decodings
  typedef union packed {
    i_fmt_t i;
    u_fmt_t u;
  } inst_u;

endpackage

`default_nettype wire

/* source/rv_regfile.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_regfile (
  input  wire logic                  clk,
  input  wire rv_isa_pkg::reg_addr_t rs1_addr,
  input  wire rv_isa_pkg::reg_addr_t rd_addr,
  input  wire rv_isa_pkg::word_t     rd_wdata,
  input  wire logic                  rd_wen,
  output rv_isa_pkg::word_t          rs1_data
);

  // x0 slot exists but is never written
  rv_isa_pkg::word_t regs [0:`RV_NUM_REGS-1];

  // write at the edge, x0 writes dropped
  always_ff @(posedge clk) begin
    if (rd_wen && (rd_addr != `RV_REG_AW'(0))) begin
      regs[rd_addr] <= rd_wdata;
    end
  end

  // async read, x0 forced to zero
  assign rs1_data = (rs1_addr == `RV_REG_AW'(0)) ? '0 : regs[rs1_addr];

endmodule

`default_nettype wire

/* test/rv_core_properties.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_core_properties (
  input wire logic              clk,
  input wire logic              rst_n,
  input wire rv_isa_pkg::word_t pc,
  input wire logic              halt
);

  // no history before the first edge
  logic past_valid = 1'b0;

  always_ff @(posedge clk) begin
    past_valid <= 1'b1;
  end

  // halt is sticky until reset
  halt_sticky: assert property (@(posedge clk)
    past_valid && $past(rst_n) && $past(halt) |-> halt)
    else $error("halt fell while out of reset");

  // halted core keeps its pc
  pc_frozen: assert property (@(posedge clk)
    past_valid && $past(rst_n) && $past(halt) |-> $stable(pc))
    else $error("pc moved while halted");

  // reset loads the boot address
  pc_after_reset: assert property (@(posedge clk)
    past_valid && !$past(rst_n) |-> pc == `RV_RESET_PC)
    else $error("pc is not the reset pc after reset");

endmodule

bind rv_core rv_core_properties u_props (
  .clk   (clk),
  .rst_n (rst_n),
  .pc    (pc),
  .halt  (halt)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // low for 8 edges, released just after the 8th
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_rv_core.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module tb_rv_core;

  // cycles per test, also feed the watchdog
  localparam int RESET_CYCLES  = 8;
  localparam int SEQ_COUNT     = 12;
  localparam int JAL_COUNT     = 8;
  localparam int JALR_ROUNDS   = 4;
  localparam int RESULT_ROUNDS = 3;
  localparam int EBREAK_CYCLES = 5;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + SEQ_COUNT + JAL_COUNT +
                                 JALR_ROUNDS * 3 + 2 + RESULT_ROUNDS * 6 + EBREAK_CYCLES;
  localparam int WATCHDOG_NS   = TOTAL_CYCLES * 10 * 2;
  localparam rv_isa_pkg::word_t EVEN_MASK = 32'hFFFF_FFFE;

  logic                clk;
  logic                rst_n;
  rv_isa_pkg::inst_u   inst;
  rv_isa_pkg::word_t   pc;
  logic                halt;

  // scoreboard state
  rv_isa_pkg::word_t   exp_pc;
  string               cur_test;
  int                  err_count;
  int                  check_count;
  int                  test_count;
  int                  failed_tests;
  int                  test_err_base;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_core u_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .inst  (inst),
    .pc    (pc),
    .halt  (halt)
  );

  // i-type word, funct3 left at zero
  function automatic rv_isa_pkg::inst_u enc_i(input logic [6:0] opcode,
      input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::reg_addr_t rs1,
      input logic [11:0] imm);
    rv_isa_pkg::inst_u w;
    w.i.imm    = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = 3'b000;
    w.i.rd     = rd;
    w.i.opcode = opcode;
    return w;
  endfunction

  function automatic rv_isa_pkg::inst_u enc_u(input rv_isa_pkg::opcode_e opcode,
      input rv_isa_pkg::reg_addr_t rd, input logic [19:0] imm);
    rv_isa_pkg::inst_u w;
    w.u.imm    = imm;
    w.u.rd     = rd;
    w.u.opcode = opcode;
    return w;
  endfunction

  // jal, offset bits placed as imm[20|10:1|11|19:12]
  function automatic rv_isa_pkg::inst_u enc_jal(input rv_isa_pkg::reg_addr_t rd,
      input logic [20:0] off);
    return enc_u(rv_isa_pkg::JAL, rd, {off[20], off[10:1], off[11], off[19:12]});
  endfunction

  function automatic rv_isa_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic rv_isa_pkg::word_t sext21(input logic [20:0] v);
    return {{11{v[20]}}, v};
  endfunction

  // x1..x31
  function automatic rv_isa_pkg::reg_addr_t rand_reg();
    return rv_isa_pkg::reg_addr_t'($urandom_range(31, 1));
  endfunction

  task automatic check_pc(input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch pc in %s: got 0x%h expected 0x%h", cur_test, got, exp);
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch halt in %s: got 0x%h expected 0x%h", cur_test, got, exp);
    end
  endtask

  // drive at edge+1, check at the following edge+1
  task automatic run_inst(input rv_isa_pkg::inst_u w, input rv_isa_pkg::word_t pc_exp,
      input logic halt_exp);
    inst = w;
    @(posedge clk);
    #1;
    check_pc(pc, pc_exp);
    check_halt(halt, halt_exp);
    exp_pc = pc_exp;
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_count;
    test_count++;
  endtask

  task automatic finish_test();
    if (err_count == test_err_base) begin
      $display("test %s: ok", cur_test);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", cur_test, err_count - test_err_base);
    end
  endtask

  // lui + addi, upper part rounded for the signed low half
  task automatic load_reg(input rv_isa_pkg::reg_addr_t r, input rv_isa_pkg::word_t v);
    rv_isa_pkg::word_t hi;
    hi = v + 32'h0000_0800;
    run_inst(enc_u(rv_isa_pkg::LUI, r, hi[31:12]), exp_pc + 32'd4, 1'b0);
    run_inst(enc_i(rv_isa_pkg::OP_IMM, r, r, v[11:0]), exp_pc + 32'd4, 1'b0);
  endtask

  task automatic test_reset();
    start_test("reset");
    check_pc(pc, `RV_RESET_PC);
    check_halt(halt, 1'b0);
    exp_pc = `RV_RESET_PC;
    finish_test();
  endtask

  task automatic test_sequential();
    rv_isa_pkg::inst_u w;
    int unsigned kind;
    start_test("sequential");
    for (int k = 0; k < SEQ_COUNT; k++) begin
      kind = $urandom_range(2, 0);
      case (kind)
        0: w = enc_i(rv_isa_pkg::OP_IMM, rand_reg(), rand_reg(), 12'($urandom));
        1: w = enc_u(rv_isa_pkg::LUI, rand_reg(), 20'($urandom));
        default: w = enc_u(rv_isa_pkg::AUIPC, rand_reg(), 20'($urandom));
      endcase
      run_inst(w, exp_pc + 32'd4, 1'b0);
    end
    finish_test();
  endtask

  task automatic test_jal();
    logic [20:0] off;
    start_test("jal");
    for (int k = 0; k < JAL_COUNT; k++) begin
      off     = 21'($urandom);
      off[0]  = 1'b0;
      // odd rounds jump backward
      off[20] = k[0];
      run_inst(enc_jal(rand_reg(), off), exp_pc + sext21(off), 1'b0);
    end
    finish_test();
  endtask

  task automatic test_jalr();
    rv_isa_pkg::reg_addr_t r;
    rv_isa_pkg::word_t     v;
    logic [11:0]           imm;
    start_test("jalr");
    for (int k = 0; k < JALR_ROUNDS; k++) begin
      r   = rand_reg();
      v   = $urandom;
      imm = 12'($urandom);
      load_reg(r, v);
      run_inst(enc_i(rv_isa_pkg::JALR, '0, r, imm), (v + sext12(imm)) & EVEN_MASK, 1'b0);
    end
    // x0 must ignore the write
    imm = 12'($urandom);
    run_inst(enc_i(rv_isa_pkg::OP_IMM, '0, '0, 12'h5a5), exp_pc + 32'd4, 1'b0);
    run_inst(enc_i(rv_isa_pkg::JALR, '0, '0, imm), sext12(imm) & EVEN_MASK, 1'b0);
    finish_test();
  endtask

  // each written value read back through a jalr with imm 0
  task automatic test_results();
    rv_isa_pkg::reg_addr_t r;
    rv_isa_pkg::word_t     base;
    logic [19:0]           u;
    logic [20:0]           off;
    start_test("results");
    for (int k = 0; k < RESULT_ROUNDS; k++) begin
      r = rand_reg();
      u = 20'($urandom);
      run_inst(enc_u(rv_isa_pkg::LUI, r, u), exp_pc + 32'd4, 1'b0);
      run_inst(enc_i(rv_isa_pkg::JALR, '0, r, '0), {u, 12'h000}, 1'b0);
      r    = rand_reg();
      u    = 20'($urandom);
      base = exp_pc;
      run_inst(enc_u(rv_isa_pkg::AUIPC, r, u), base + 32'd4, 1'b0);
      run_inst(enc_i(rv_isa_pkg::JALR, '0, r, '0), (base + {u, 12'h000}) & EVEN_MASK, 1'b0);
      r      = rand_reg();
      off    = 21'($urandom);
      off[0] = 1'b0;
      base   = exp_pc;
      run_inst(enc_jal(r, off), base + sext21(off), 1'b0);
      run_inst(enc_i(rv_isa_pkg::JALR, '0, r, '0), (base + 32'd4) & EVEN_MASK, 1'b0);
    end
    finish_test();
  endtask

  // pc stays on the ebreak, nothing after it counts
  task automatic test_ebreak();
    rv_isa_pkg::word_t base;
    start_test("ebreak");
    base = exp_pc;
    run_inst(enc_i(rv_isa_pkg::SYSTEM, '0, '0, 12'd1), base, 1'b1);
    run_inst(enc_jal(rand_reg(), 21'h000100), base, 1'b1);
    run_inst(enc_i(rv_isa_pkg::OP_IMM, rand_reg(), '0, 12'h07f), base, 1'b1);
    run_inst(enc_u(rv_isa_pkg::LUI, rand_reg(), 20'($urandom)), base, 1'b1);
    run_inst(enc_i(rv_isa_pkg::JALR, '0, '0, 12'h100), base, 1'b1);
    finish_test();
  endtask

  initial begin
    void'($urandom(51));
    inst          = enc_i(rv_isa_pkg::OP_IMM, '0, '0, '0);
    exp_pc        = '0;
    cur_test      = "";
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    failed_tests  = 0;
    test_err_base = 0;
    wait (rst_n === 1'b1);
    test_reset();
    test_sequential();
    test_jal();
    test_jalr();
    test_results();
    test_ebreak();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // twice the cycle budget of all tests
  initial begin
    #(WATCHDOG_NS);
    $display("run timed out after %0d ns in test %s", WATCHDOG_NS, cur_test);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire
